/* Makefile */
TOP  := kme_core_glue_tb
SRCS := $(shell cat kme_core_glue.f)

.PHONY: all run clean

all: run

obj_dir/V$(TOP): kme_core_glue.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f kme_core_glue.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "Done: no errors" > /dev/null

clean:
	rm -rf obj_dir

/* kme_clk_gen.sv */
//////////////////////////////
// kme testbench clock and reset
// Free running clock and an active low reset held for a number of cycles.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_clk_gen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;                               // released on a rising edge.
   end

endmodule

`default_nettype wire

/* kme_core_glue.f */
kme_glue_pkg.sv
kme_stat_counter.sv
kme_stat_bank.sv
kme_idle_tracker.sv
kme_core_glue.sv
kme_clk_gen.sv
kme_core_glue_checker.sv
kme_core_glue_tb.sv

/* kme_core_glue.sv */
//////////////////////////////
// kme core glue
// Interrupt merge, inbound ready override, debug disable register,
// statistics counters and idle tracking for the key engine core.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_core_glue
   import kme_glue_pkg::*;
#(
   parameter int NUM_SA = 32
) (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   // debug
   input  wire logic                 disable_debug_cmd,
   output logic                      disable_debug_cmd_q,
   // interrupts
   input  wire logic                 cceip_encrypt_tag_fail,
   input  wire logic                 cceip_validate_tag_fail,
   input  wire logic                 cddip_decrypt_tag_fail,
   output logic                      gcm_tag_fail_int,
   output logic                      txc_bp_int,
   // backpressure and inbound ready
   input  wire logic [NUM_RSM-1:0]   cceip_ob_full,
   input  wire logic [NUM_RSM-1:0]   cddip_ob_full,
   output logic [2*NUM_RSM-1:0]      rsm_backpressure,
   input  wire logic                 tready_override,
   input  wire logic                 core_ib_tready,
   output logic                      ib_tready,
   // statistics
   input  wire logic                 sa_snap,
   input  wire logic                 sa_clear,
   input  wire sa_sel_t              sa_event_sel [NUM_SA],
   input  wire sa_event_vec_t        stat_events,
   output sa_count_t                 sa_count     [NUM_SA],
   output sa_count_t                 sa_snapshot  [NUM_SA],
   // idle tracking
   input  wire logic                 kme_slv_empty,
   input  wire logic                 drng_idle,
   input  wire logic                 tlv_parser_idle,
   input  wire logic                 tlv_start,
   input  wire logic [NUM_RSM-1:0]   cceip_rsm_end,
   input  wire logic [NUM_RSM-1:0]   cddip_rsm_end,
   input  wire logic [NUM_RSM-1:0]   cceip_rsm_idle,
   input  wire logic [NUM_RSM-1:0]   cddip_rsm_idle,
   output logic                      kme_idle,
   output idle_status_t              idle_status
);

   assign gcm_tag_fail_int = cceip_encrypt_tag_fail | cceip_validate_tag_fail |
                             cddip_decrypt_tag_fail;

   assign rsm_backpressure = {cddip_ob_full, cceip_ob_full};   // cddip in the upper half.
   assign ib_tready        = tready_override ? 1'b0 : core_ib_tready;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         txc_bp_int          <= 1'b0;
         disable_debug_cmd_q <= 1'b0;
      end else begin
         txc_bp_int          <= ~ib_tready;          // raised for every cycle without ready.
         disable_debug_cmd_q <= disable_debug_cmd;
      end
   end

   kme_stat_bank #(.NUM_SA(NUM_SA)) u_stat_bank (
      .clk          (clk),
      .rst_n        (rst_n),
      .events       (stat_events),
      .sa_snap      (sa_snap),
      .sa_clear     (sa_clear),
      .sa_event_sel (sa_event_sel),
      .sa_count     (sa_count),
      .sa_snapshot  (sa_snapshot)
   );

   kme_idle_tracker u_idle_tracker (
      .clk             (clk),
      .rst_n           (rst_n),
      .kme_slv_empty   (kme_slv_empty),
      .drng_idle       (drng_idle),
      .tlv_parser_idle (tlv_parser_idle),
      .tlv_start       (tlv_start),
      .cceip_rsm_end   (cceip_rsm_end),
      .cddip_rsm_end   (cddip_rsm_end),
      .cceip_rsm_idle  (cceip_rsm_idle),
      .cddip_rsm_idle  (cddip_rsm_idle),
      .kme_idle        (kme_idle),
      .idle_status     (idle_status)
   );

endmodule

`default_nettype wire

/* kme_core_glue_checker.sv */
//////////////////////////////
// kme idle tracker checker
// Concurrent assertions on the key TLV in-flight count and idle flag.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_core_glue_checker
   import kme_glue_pkg::*;
(
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   input  wire logic [NUM_RSM-1:0]     cceip_rsm_end,
   input  wire logic [NUM_RSM-1:0]     cddip_rsm_end,
   input  wire logic [IN_FLIGHT_W-1:0] num_in_flight,
   input  wire logic                   kme_idle
);

   a_end_needs_tlv : assert property (@(posedge clk) disable iff (!rst_n)
      (num_in_flight == '0) |-> !(|{cceip_rsm_end, cddip_rsm_end}))
      else $error("key TLV end pulse while nothing is in flight");

   // the idle flag is registered, so it looks at the count one edge back.
   a_idle_needs_empty : assert property (@(posedge clk) disable iff (!rst_n)
      kme_idle |-> ($past(num_in_flight) == '0))
      else $error("engine idle while key TLVs were in flight");

   a_step_of_one : assert property (@(posedge clk) disable iff (!rst_n)
      (num_in_flight == $past(num_in_flight)) ||
      (num_in_flight == $past(num_in_flight) + IN_FLIGHT_W'(1)) ||
      (num_in_flight == $past(num_in_flight) - IN_FLIGHT_W'(1)))
      else $error("in-flight count moved by more than one in a cycle");

endmodule

bind kme_idle_tracker kme_core_glue_checker u_checker (
   .clk           (clk),
   .rst_n         (rst_n),
   .cceip_rsm_end (cceip_rsm_end),
   .cddip_rsm_end (cddip_rsm_end),
   .num_in_flight (num_in_flight),
   .kme_idle      (kme_idle)
);

`default_nettype wire

/* kme_core_glue_tb.sv */
//////////////////////////////
// kme core glue testbench
// Random stimulus against a cycle reference model of the glue block.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_core_glue_tb
   import kme_glue_pkg::*;
();

   localparam int NUM_SA = 8;

   logic clk, rst_n;
   logic disable_debug_cmd, disable_debug_cmd_q;
   logic cceip_encrypt_tag_fail, cceip_validate_tag_fail, cddip_decrypt_tag_fail;
   logic gcm_tag_fail_int, txc_bp_int;
   logic [NUM_RSM-1:0] cceip_ob_full, cddip_ob_full;
   logic [2*NUM_RSM-1:0] rsm_backpressure;
   logic tready_override, core_ib_tready, ib_tready;
   logic sa_snap, sa_clear;
   sa_sel_t sa_event_sel [NUM_SA];
   sa_event_vec_t stat_events;
   sa_count_t sa_count [NUM_SA];
   sa_count_t sa_snapshot [NUM_SA];
   logic kme_slv_empty, drng_idle, tlv_parser_idle, tlv_start, kme_idle;
   logic [NUM_RSM-1:0] cceip_rsm_end, cddip_rsm_end, cceip_rsm_idle, cddip_rsm_idle;
   idle_status_t idle_status;

   sa_count_t exp_count [NUM_SA];
   sa_count_t exp_snapshot [NUM_SA];
   logic exp_snap_prev, exp_snap_d1, exp_snap_d2, exp_clear_prev, exp_clear_d1, exp_clear_d2;
   logic exp_txc, exp_debug_q, exp_idle;
   int exp_in_flight;

   logic [31:0] rng_state;
   sa_count_t tally [NUM_SA];
   sa_count_t held_snap [NUM_SA];
   int drive_in_flight, value_errors, timeouts;

   kme_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

   kme_core_glue #(.NUM_SA(NUM_SA)) uut (.*);

   //////////////////////////////
   // reference model
   //////////////////////////////
   function automatic logic [31:0] next_random();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic logic selected_event(input sa_event_vec_t ev, input sa_sel_t sel);
      if (sel >= NUM_SA_EVENTS) return 1'b0;
      return ev[sel];
   endfunction

   function automatic idle_status_t expected_status(input int in_flight);
      return idle_status_t'({kme_slv_empty, drng_idle, tlv_parser_idle, in_flight == 0,
                             cceip_rsm_idle, cddip_rsm_idle, IN_FLIGHT_W'(in_flight), 1'b0});
   endfunction

   always @(posedge clk) begin
      if (!rst_n) begin
         {exp_snap_prev, exp_snap_d1, exp_snap_d2} = '0;
         {exp_clear_prev, exp_clear_d1, exp_clear_d2} = '0;
         {exp_txc, exp_debug_q, exp_idle} = '0;
         exp_in_flight = 0;
         for (int i = 0; i < NUM_SA; i++) begin
            exp_count[i] = '0;
            exp_snapshot[i] = '0;
         end
      end else begin
         for (int i = 0; i < NUM_SA; i++) begin
            if (exp_snap_d2) exp_snapshot[i] = exp_count[i];
            if (exp_clear_d2) exp_count[i] = '0;
            else if (selected_event(stat_events, sa_event_sel[i])) exp_count[i] += 1;
         end
         exp_snap_d2 = exp_snap_d1;                 // rising edge acts two edges later.
         exp_snap_d1 = sa_snap & ~exp_snap_prev;
         exp_snap_prev = sa_snap;
         exp_clear_d2 = exp_clear_d1;
         exp_clear_d1 = sa_clear & ~exp_clear_prev;
         exp_clear_prev = sa_clear;
         exp_txc = tready_override | ~core_ib_tready;
         exp_debug_q = disable_debug_cmd;
         exp_idle = kme_slv_empty & drng_idle & tlv_parser_idle & (exp_in_flight == 0) &
                    (&cceip_rsm_idle) & (&cddip_rsm_idle);
         if (tlv_start && !(|{cceip_rsm_end, cddip_rsm_end})) exp_in_flight++;
         else if (!tlv_start && |{cceip_rsm_end, cddip_rsm_end}) exp_in_flight--;
      end
   end

   //////////////////////////////
   // checks
   //////////////////////////////
   task automatic check_count(input string name, input sa_count_t expected,
                              input sa_count_t actual);
      if (actual !== expected) begin
         value_errors++;
         $display("error %s: expected %0d, actual %0d", name, expected, actual);
      end
   endtask

   task automatic check_status(input string name, input idle_status_t expected,
                               input idle_status_t actual);
      if (actual !== expected) begin
         value_errors++;
         $display("error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         value_errors++;
         $display("error %s: expected %b, actual %b", name, expected, actual);
      end
   endtask

   always @(negedge clk) begin
      if (rst_n) begin
         check_bit("gcm_tag_fail_int", cceip_encrypt_tag_fail | cceip_validate_tag_fail |
                   cddip_decrypt_tag_fail, gcm_tag_fail_int);
         for (int b = 0; b < NUM_RSM; b++) begin
            check_bit("rsm_backpressure cceip", cceip_ob_full[b], rsm_backpressure[b]);
            check_bit("rsm_backpressure cddip", cddip_ob_full[b], rsm_backpressure[b + NUM_RSM]);
         end
         check_bit("ib_tready", !tready_override && core_ib_tready, ib_tready);
         check_bit("txc_bp_int", exp_txc, txc_bp_int);
         check_bit("disable_debug_cmd_q", exp_debug_q, disable_debug_cmd_q);
         check_bit("kme_idle", exp_idle, kme_idle);
         check_status("idle_status", expected_status(exp_in_flight), idle_status);
         for (int i = 0; i < NUM_SA; i++) begin
            check_count($sformatf("count[%0d]", i), exp_count[i], sa_count[i]);
            check_count($sformatf("snapshot[%0d]", i), exp_snapshot[i], sa_snapshot[i]);
         end
      end
   end

   //////////////////////////////
   // stimulus
   //////////////////////////////
   task automatic drive_idle_inputs(input logic allow_start);
      logic [31:0] r;
      logic start;
      logic [2*NUM_RSM-1:0] ends;
      r = next_random();
      start = allow_start && (r[2:0] < 3'd3);
      ends = '0;
      if (drive_in_flight > 0 && r[5:3] < 3'd3) ends[r[8:6]] = 1'b1;   // one end at a time.
      tlv_start <= start;
      {cddip_rsm_end, cceip_rsm_end} <= ends;
      if (start && ends == '0) drive_in_flight++;
      else if (!start && ends != '0) drive_in_flight--;
      kme_slv_empty <= r[11:9] != 3'd0;
      drng_idle <= r[14:12] != 3'd0;
      tlv_parser_idle <= r[17:15] != 3'd0;
      cceip_rsm_idle <= (r[19:18] != 2'd0) ? 4'hf : r[23:20];
      cddip_rsm_idle <= (r[25:24] != 2'd0) ? 4'hf : r[29:26];
   endtask

   task automatic drive_cycle(input logic events_on, input logic allow_start);
      logic [31:0] r;
      sa_event_vec_t ev;
      r = next_random();
      disable_debug_cmd <= r[0];
      cceip_encrypt_tag_fail <= r[3:1] == 3'd0;
      cceip_validate_tag_fail <= r[6:4] == 3'd0;
      cddip_decrypt_tag_fail <= r[9:7] == 3'd0;
      tready_override <= r[12:10] == 3'd0;
      core_ib_tready <= r[13] | r[14];
      cceip_ob_full <= r[18:15];
      cddip_ob_full <= r[22:19];
      ev = events_on ? sa_event_vec_t'(next_random()) : '0;
      stat_events <= ev;
      for (int i = 0; i < NUM_SA; i++) begin
         if (selected_event(ev, sa_event_sel[i])) tally[i] += 1;
      end
      drive_idle_inputs(allow_start);
   endtask

   task automatic run_cycles(input int n, input logic events_on);
      repeat (n) begin
         @(posedge clk);
         drive_cycle(events_on, 1'b1);
      end
   endtask

   task automatic wait_for_reset(input int limit);
      int n;
      n = 0;
      while (!rst_n && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (!rst_n) begin
         timeouts++;
         $display("timeout: reset was not released within %0d cycles", limit);
      end
   endtask

   task automatic drain_in_flight(input int limit);
      int n;
      n = 0;
      while (drive_in_flight != 0 && n < limit) begin
         @(posedge clk);
         drive_cycle(1'b0, 1'b0);
         n++;
      end
      if (drive_in_flight != 0) begin
         timeouts++;
         $display("timeout: key TLVs still in flight after %0d cycles", limit);
      end
   endtask

   task automatic wait_for_idle(input int limit);
      int n;
      n = 0;
      while (kme_idle !== 1'b1 && n < limit) begin
         @(negedge clk);
         n++;
      end
      if (kme_idle !== 1'b1) begin
         timeouts++;
         $display("timeout: engine idle flag did not rise within %0d cycles", limit);
      end
   endtask

   initial begin
      rng_state = 32'h782896a4;
      value_errors = 0;
      timeouts = 0;
      drive_in_flight = 0;
      {disable_debug_cmd, cceip_encrypt_tag_fail, cceip_validate_tag_fail} = '0;
      {cddip_decrypt_tag_fail, tready_override, core_ib_tready, sa_snap, sa_clear} = '0;
      {cceip_ob_full, cddip_ob_full, stat_events} = '0;
      {kme_slv_empty, drng_idle, tlv_parser_idle, tlv_start} = '0;
      {cceip_rsm_end, cddip_rsm_end, cceip_rsm_idle, cddip_rsm_idle} = '0;
      for (int i = 0; i < NUM_SA; i++) begin
         sa_event_sel[i] = '0;
         tally[i] = '0;
      end
      wait_for_reset(40);

      // counting with fixed, random and out-of-range selects.
      @(posedge clk);
      sa_event_sel[0] <= EV_DRBG_RESEED;
      sa_event_sel[1] <= EV_VF_PF_FAIL;
      sa_event_sel[2] <= 5'd29;
      sa_event_sel[3] <= EV_CDDIP_STALL_BASE + 5'd3;
      for (int i = 4; i < NUM_SA; i++) sa_event_sel[i] <= sa_sel_t'(next_random());
      drive_cycle(1'b0, 1'b1);
      run_cycles(300, 1'b1);
      run_cycles(3, 1'b0);
      @(posedge clk);
      sa_snap <= 1'b1;
      drive_cycle(1'b0, 1'b1);
      run_cycles(4, 1'b0);
      @(negedge clk);
      for (int i = 0; i < NUM_SA; i++) begin
         check_count($sformatf("snap total[%0d]", i), tally[i], sa_snapshot[i]);
         check_count($sformatf("count total[%0d]", i), tally[i], sa_count[i]);
         held_snap[i] = tally[i];
      end

      // snap stays high while events continue.
      run_cycles(100, 1'b1);
      run_cycles(2, 1'b0);
      @(negedge clk);
      for (int i = 0; i < NUM_SA; i++) begin
         check_count($sformatf("held snap[%0d]", i), held_snap[i], sa_snapshot[i]);
         check_count($sformatf("live count[%0d]", i), tally[i], sa_count[i]);
      end

      // clear is raised and held.
      @(posedge clk);
      sa_snap <= 1'b0;
      sa_clear <= 1'b1;
      drive_cycle(1'b0, 1'b1);
      run_cycles(4, 1'b0);
      @(negedge clk);
      for (int i = 0; i < NUM_SA; i++) begin
         check_count($sformatf("cleared[%0d]", i), '0, sa_count[i]);
         tally[i] = '0;
      end
      run_cycles(60, 1'b1);
      run_cycles(2, 1'b0);
      @(negedge clk);
      for (int i = 0; i < NUM_SA; i++) begin
         check_count($sformatf("recount[%0d]", i), tally[i], sa_count[i]);
         check_count($sformatf("kept snap[%0d]", i), held_snap[i], sa_snapshot[i]);
      end
      @(posedge clk);
      sa_clear <= 1'b0;
      drive_cycle(1'b0, 1'b1);

      // idle tracking runs on its own, then drains to an idle engine.
      run_cycles(200, 1'b1);
      drain_in_flight(1000);
      @(posedge clk);
      tlv_start <= 1'b0;
      cceip_rsm_end <= '0;
      cddip_rsm_end <= '0;
      kme_slv_empty <= 1'b1;
      drng_idle <= 1'b1;
      tlv_parser_idle <= 1'b1;
      cceip_rsm_idle <= '1;
      cddip_rsm_idle <= '1;
      @(negedge clk);
      wait_for_idle(20);

      $display("value errors: %0d, timeouts: %0d", value_errors, timeouts);
      if (value_errors == 0 && timeouts == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* kme_glue_pkg.sv */
//////////////////////////////
// kme core glue shared types
// Counter, event, selector and idle-status definitions for the key
// management engine glue logic.
//////////////////////////////
`default_nettype none

package kme_glue_pkg;

   // statistics counters.
   localparam int SA_COUNT_W    = 50;
   localparam int NUM_SA_EVENTS = 25;

   typedef logic [SA_COUNT_W-1:0]    sa_count_t;
   typedef logic [NUM_SA_EVENTS-1:0] sa_event_vec_t;
   typedef logic [4:0]               sa_sel_t;

   // event vector bit positions.
   localparam sa_sel_t EV_DRBG_RESEED      = 5'd0;
   localparam sa_sel_t EV_EXPIRED_SEED     = 5'd1;
   localparam sa_sel_t EV_AUX_KEY_BASE     = 5'd2;   // aux key types 0 to 13.
   localparam sa_sel_t EV_CCEIP_STALL_BASE = 5'd16;
   localparam sa_sel_t EV_CDDIP_STALL_BASE = 5'd20;
   localparam sa_sel_t EV_VF_PF_FAIL       = 5'd24;

   // idle tracking.
   localparam int NUM_RSM     = 4;
   localparam int IN_FLIGHT_W = 20;

   typedef struct packed {
      logic                   kme_slv_empty;
      logic                   drng_idle;
      logic                   tlv_parser_idle;
      logic                   no_key_tlv_in_flight;
      logic [NUM_RSM-1:0]     cceip_rsm_idle;
      logic [NUM_RSM-1:0]     cddip_rsm_idle;
      logic [IN_FLIGHT_W-1:0] num_key_tlvs_in_flight;
      logic                   spare;                  // always reads zero.
   } idle_status_t;

endpackage

`default_nettype wire

/* kme_idle_tracker.sv */
//////////////////////////////
// kme idle tracker
// Counts key TLVs in flight and derives the engine idle flag and
// the per component idle status word.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_idle_tracker
   import kme_glue_pkg::*;
(
   input  wire logic               clk,
   input  wire logic               rst_n,
   input  wire logic               kme_slv_empty,
   input  wire logic               drng_idle,
   input  wire logic               tlv_parser_idle,
   input  wire logic               tlv_start,
   input  wire logic [NUM_RSM-1:0] cceip_rsm_end,
   input  wire logic [NUM_RSM-1:0] cddip_rsm_end,
   input  wire logic [NUM_RSM-1:0] cceip_rsm_idle,
   input  wire logic [NUM_RSM-1:0] cddip_rsm_idle,
   output logic                    kme_idle,
   output idle_status_t            idle_status
);

   logic [IN_FLIGHT_W-1:0] num_in_flight;
   logic                   any_end;
   logic                   none_in_flight;

   assign any_end        = (|cceip_rsm_end) | (|cddip_rsm_end);
   assign none_in_flight = (num_in_flight == '0);

   // start and end on the same edge cancel out.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         num_in_flight <= '0;
      end else begin
         case ({tlv_start, any_end})
            2'b10:   num_in_flight <= num_in_flight + 1'b1;
            2'b01:   num_in_flight <= num_in_flight - 1'b1;
            default: num_in_flight <= num_in_flight;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         kme_idle <= 1'b0;
      end else begin
         kme_idle <= kme_slv_empty & drng_idle & tlv_parser_idle & none_in_flight &
                     (&cceip_rsm_idle) & (&cddip_rsm_idle);
      end
   end

   always_comb begin
      idle_status.kme_slv_empty          = kme_slv_empty;
      idle_status.drng_idle              = drng_idle;
      idle_status.tlv_parser_idle        = tlv_parser_idle;
      idle_status.no_key_tlv_in_flight   = none_in_flight;
      idle_status.cceip_rsm_idle         = cceip_rsm_idle;
      idle_status.cddip_rsm_idle         = cddip_rsm_idle;
      idle_status.num_key_tlvs_in_flight = num_in_flight;
      idle_status.spare                  = 1'b0;
   end

endmodule

`default_nettype wire

/* kme_stat_bank.sv */
//////////////////////////////
// kme statistics bank
// Edge detects the global snap and clear levels and runs the array
// of statistics counters off the resulting pulses.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_stat_bank
   import kme_glue_pkg::*;
#(
   parameter int NUM_SA = 32
) (
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire sa_event_vec_t events,
   input  wire logic          sa_snap,
   input  wire logic          sa_clear,
   input  wire sa_sel_t       sa_event_sel [NUM_SA],
   output sa_count_t          sa_count     [NUM_SA],
   output sa_count_t          sa_snapshot  [NUM_SA]
);

   logic snap_q, snap_qq, snap_pulse;
   logic clear_q, clear_qq, clear_pulse;

   //////////////////////////////
   // global control edge detect
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         snap_q      <= 1'b0;
         snap_qq     <= 1'b0;
         snap_pulse  <= 1'b0;
         clear_q     <= 1'b0;
         clear_qq    <= 1'b0;
         clear_pulse <= 1'b0;
      end else begin
         snap_q      <= sa_snap;
         snap_qq     <= snap_q;
         snap_pulse  <= snap_q & ~snap_qq;       // one cycle per rising edge.
         clear_q     <= sa_clear;
         clear_qq    <= clear_q;
         clear_pulse <= clear_q & ~clear_qq;
      end
   end

   //////////////////////////////
   // counter array
   //////////////////////////////
   for (genvar i = 0; i < NUM_SA; i++) begin : g_cnt
      kme_stat_counter u_cnt (
         .clk         (clk),
         .rst_n       (rst_n),
         .events      (events),
         .event_sel   (sa_event_sel[i]),
         .clear_pulse (clear_pulse),
         .snap_pulse  (snap_pulse),
         .count       (sa_count[i]),
         .snapshot    (sa_snapshot[i])
      );
   end

endmodule

`default_nettype wire

/* kme_stat_counter.sv */
//////////////////////////////
// kme statistics counter
// Counts one selected event and keeps a snapshot of the count.
//////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module kme_stat_counter
   import kme_glue_pkg::*;
(
   input  wire logic          clk,
   input  wire logic          rst_n,
   input  wire sa_event_vec_t events,
   input  wire sa_sel_t       event_sel,
   input  wire logic          clear_pulse,
   input  wire logic          snap_pulse,
   output sa_count_t          count,
   output sa_count_t          snapshot
);

   logic event_hit;

   // selects past the last event never count.
   always_comb begin
      if (event_sel < sa_sel_t'(NUM_SA_EVENTS)) begin
         event_hit = events[event_sel];
      end else begin
         event_hit = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         count    <= '0;
         snapshot <= '0;
      end else begin
         if (clear_pulse) begin
            count <= '0;                           // an event on this edge is dropped.
         end else if (event_hit) begin
            count <= count + sa_count_t'(1);
         end
         if (snap_pulse) begin
            snapshot <= count;                     // takes the value before any clear.
         end
      end
   end

endmodule

`default_nettype wire
